// ==== Bender.yml ====
package:
  name: u1_ctrl

sources:
  - logic/u1_ctrl_pkg.sv
  - logic/wb_slave_decode.sv
  - logic/misc_regs.sv
  - logic/settings_bridge.sv
  - logic/reset_ctrl.sv
  - logic/time_keeper.sv
  - logic/status_readback.sv
  - logic/u1_ctrl_core.sv
  - target: test
    files:
      - bench/ctrl_checker.sv
      - bench/tb_u1_ctrl.sv

// ==== bench/ctrl_checker.sv ====
////////////////////////////////////////////////////////////
// bus and pin response checker
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ctrl_checker
   (input  wire                   wb_clk,
    input  wire                   chk_stb_i,    // one cycle per finished test
    input  wire [7:0]             test_idx_i,
    input  wire                   bus_op_i,     // test ended with an ack
    input  wire [1:0]             chk_kind_i,
    input  u1_ctrl_pkg::wb_data_t exp_i,
    input  wire                   wb_ack_i,
    input  u1_ctrl_pkg::wb_data_t wb_dat_i,
    input  wire [2:0]             debug_led_i,
    input  wire                   cgen_sync_b_i,
    input  wire                   cgen_ref_sel_i,
    output int                    pass_cnt_o,
    output int                    fail_cnt_o);

   localparam logic [1:0] CHK_EQ  = 2'd1;
   localparam logic [1:0] CHK_GE  = 2'd2;
   localparam logic [1:0] CHK_PIN = 2'd3;

   logic       ok;
   logic [4:0] pins;
   int         ack_cnt;   // ack cycles seen since the last finished test
   int         n_ack;
   int         n_exp;

   assign pins = {cgen_sync_b_i, cgen_ref_sel_i, debug_led_i};

   initial
   begin
      pass_cnt_o = 0;
      fail_cnt_o = 0;
      ack_cnt    = 0;
   end

   // sampled on the edge that closes the ack cycle
   always @(posedge wb_clk)
   begin
      if (chk_stb_i)
      begin
         ok    = 1'b1;
         n_ack = ack_cnt + ((wb_ack_i === 1'b1) ? 1 : 0);
         n_exp = bus_op_i ? 1 : 0;   // exactly one ack per bus access
         if (n_ack != n_exp)
         begin
            $display("Test %0d failed: %0d acknowledge cycles seen, expected %0d",
                     test_idx_i, n_ack, n_exp);
            ok = 1'b0;
         end
         ack_cnt = 0;
         case (chk_kind_i)
            CHK_EQ :
               if (wb_dat_i !== exp_i)
               begin
                  $display("Fail test %0d: wb_dat_o = %h, expected %h",
                           test_idx_i, wb_dat_i, exp_i);
                  ok = 1'b0;
               end
            CHK_GE :
               if ($isunknown(wb_dat_i) || (wb_dat_i < exp_i))
               begin
                  $display("Fail test %0d: wb_dat_o = %h, expected at least %h",
                           test_idx_i, wb_dat_i, exp_i);
                  ok = 1'b0;
               end
            CHK_PIN :
               if (pins !== exp_i[4:0])
               begin
                  $display("Fail test %0d: %s = %h, expected %h", test_idx_i,
                           "{cgen_sync_b_o, cgen_ref_sel_o, debug_led_o}", pins, exp_i[4:0]);
                  ok = 1'b0;
               end
            default : ;   // only the ack matters
         endcase
         if (ok)
         begin
            pass_cnt_o = pass_cnt_o + 1;
            $display("test %0d ok", test_idx_i);
         end
         else
            fail_cnt_o = fail_cnt_o + 1;
      end
      else if (wb_ack_i === 1'b1)
         ack_cnt = ack_cnt + 1;
   end

endmodule

`default_nettype wire

// ==== bench/tb_u1_ctrl.sv ====
////////////////////////////////////////////////////////////
// control plane testbench
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_u1_ctrl;

   localparam int N_TESTS    = 37;
   localparam int RST_CYCLES = 3;
   localparam int LIMIT      = N_TESTS * 20 + RST_CYCLES;

   localparam logic [1:0] OP_WR = 2'd0, OP_RD = 2'd1, OP_PPS = 2'd2, OP_CGEN = 2'd3;
   localparam logic [1:0] CHK_NONE = 2'd0, CHK_EQ = 2'd1, CHK_GE = 2'd2, CHK_PIN = 2'd3;

   typedef struct packed {
      logic [1:0]            op;
      u1_ctrl_pkg::wb_addr_t adr;
      u1_ctrl_pkg::wb_data_t dat;
      logic [1:0]            chk;
      u1_ctrl_pkg::wb_data_t exp;
   } test_entry_t;

   logic                  wb_clk, wb_rst, wb_we, wb_cyc, wb_stb, wb_ack, pps;
   u1_ctrl_pkg::wb_addr_t wb_adr;
   u1_ctrl_pkg::wb_data_t wb_wdat, wb_rdat, chk_exp;
   logic [2:0]            cgen_st, debug_led;
   logic                  cgen_sync_b, cgen_ref_sel;
   logic                  chk_stb, chk_bus;
   logic [7:0]            chk_idx;
   logic [1:0]            chk_kind;
   logic [15:0]           lfsr_q;
   int                    pass_cnt, fail_cnt;
   int                    n_built;
   int                    cycle_cnt = 0;
   test_entry_t           tests [N_TESTS];

   u1_ctrl_core #(.TICKS_PER_SEC(32'd1000), .RESET_HOLD(4)) dut
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat),
      .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_dat_o(wb_rdat),
      .wb_ack_o(wb_ack), .cgen_st_i(cgen_st), .pps_i(pps), .debug_led_o(debug_led),
      .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel));

   ctrl_checker u_checker
     (.wb_clk(wb_clk), .chk_stb_i(chk_stb), .test_idx_i(chk_idx), .bus_op_i(chk_bus),
      .chk_kind_i(chk_kind), .exp_i(chk_exp), .wb_ack_i(wb_ack), .wb_dat_i(wb_rdat),
      .debug_led_i(debug_led), .cgen_sync_b_i(cgen_sync_b), .cgen_ref_sel_i(cgen_ref_sel),
      .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt));

   always #20 wb_clk = ~wb_clk;

   // watchdog
   always @(posedge wb_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= LIMIT)
      begin
         $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
         $display("*** FAILED ***");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus helpers
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   // board order of the LEDs, with both cgen pins on top
   function automatic logic [15:0] pins_for(input logic [1:0] cgen, input logic [15:0] leds);
      pins_for = {11'd0, cgen, leds[2], leds[0], leds[1]};
   endfunction

   task automatic add_test(input logic [1:0] op, input logic [10:0] adr, input logic [15:0] dat,
                           input logic [1:0] chk, input logic [15:0] exp);
      tests[n_built] = '{op: op, adr: adr, dat: dat, chk: chk, exp: exp};
      n_built = n_built + 1;
   endtask

   task automatic add_set_write(input logic [5:0] sreg, input logic [31:0] val);
      add_test(OP_WR, {3'b100, sreg, 2'b00}, val[15:0], CHK_NONE, 16'd0);
      add_test(OP_WR, {3'b100, sreg, 2'b10}, val[31:16], CHK_NONE, 16'd0);
   endtask

   task automatic add_read32(input logic [10:0] adr, input logic [31:0] exp);
      add_test(OP_RD, adr, 16'd0, CHK_EQ, exp[15:0]);
      add_test(OP_RD, adr | 11'h002, 16'd0, CHK_EQ, exp[31:16]);
   endtask

   task automatic build_table;
      logic [31:0] cgen_v, test_v, led_v, scr_v, secs_v, ticks_v;
      draw_bits(3, cgen_v);
      draw_bits(16, test_v);
      draw_bits(16, led_v);
      draw_bits(32, scr_v);
      draw_bits(32, secs_v);
      draw_bits(9, ticks_v);   // stays below one second of ticks
      n_built = 0;
      add_test(OP_CGEN, 11'h000, cgen_v[15:0], CHK_PIN, pins_for(2'b11, 16'd0));
      add_test(OP_RD, 11'h010, 16'd0, CHK_EQ, 16'd5);
      add_test(OP_RD, 11'h004, 16'd0, CHK_EQ, 16'd3);
      add_test(OP_RD, 11'h006, 16'd0, CHK_EQ, {13'd0, cgen_v[2:0]});
      add_test(OP_WR, 11'h008, test_v[15:0], CHK_NONE, 16'd0);
      add_test(OP_RD, 11'h008, 16'd0, CHK_EQ, test_v[15:0]);
      add_test(OP_WR, 11'h000, led_v[15:0], CHK_PIN, pins_for(2'b11, led_v[15:0]));
      add_test(OP_RD, 11'h000, 16'd0, CHK_EQ, led_v[15:0]);
      add_test(OP_WR, 11'h004, 16'd0, CHK_PIN, pins_for(2'b00, led_v[15:0]));   // cgen pins low
      add_set_write(6'd60, scr_v);
      add_read32(11'h390, scr_v);             // readback word 4
      add_set_write(6'd44, 32'd1);            // load at next pps
      add_set_write(6'd42, secs_v);
      add_set_write(6'd43, ticks_v);
      add_test(OP_PPS, 11'h000, 16'd0, CHK_NONE, 16'd0);
      add_read32(11'h388, secs_v);
      add_read32(11'h38C, ticks_v);
      add_test(OP_RD, 11'h380, 16'd0, CHK_GE, secs_v[15:0]);
      add_test(OP_RD, 11'h382, 16'd0, CHK_EQ, secs_v[31:16]);
      add_set_write(6'd63, 32'd0);            // global reset
      add_test(OP_RD, 11'h000, 16'd0, CHK_EQ, 16'd0);
      add_test(OP_RD, 11'h004, 16'd0, CHK_EQ, 16'd3);
      add_read32(11'h390, 32'd0);
      add_test(OP_CGEN, 11'h000, ~cgen_v[15:0], CHK_PIN, pins_for(2'b11, 16'd0));
      add_test(OP_RD, 11'h006, 16'd0, CHK_EQ, {13'd0, ~cgen_v[2:0]});   // inverted status
      add_test(OP_RD, 11'h180, 16'd0, CHK_EQ, 16'hBEEF);   // slave 3
      add_test(OP_RD, 11'h00C, 16'd0, CHK_EQ, 16'hBEEF);
      add_test(OP_RD, 11'h420, 16'd0, CHK_EQ, 16'hBEEF);   // settings slave
   endtask

   ////////////////////////////////////////////////////////////
   // bus master
   task automatic bus_cycle(input test_entry_t t);
      wb_adr  = t.adr;
      wb_wdat = t.dat;
      wb_we   = (t.op == OP_WR);
      wb_cyc  = 1'b1;
      wb_stb  = 1'b1;
      @(negedge wb_clk);
      while (wb_ack !== 1'b1)
         @(negedge wb_clk);
      wb_cyc = 1'b0;   // drop stb right after ack
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic pulse_pps;
      pps = 1'b1;
      repeat (4) @(negedge wb_clk);
      pps = 1'b0;
      repeat (2) @(negedge wb_clk);
   endtask

   task automatic run_test(input int idx);
      test_entry_t t;
      t = tests[idx];
      case (t.op)
         OP_WR, OP_RD : bus_cycle(t);
         OP_PPS       : pulse_pps();
         default      : cgen_st = t.dat[2:0];
      endcase
      chk_idx  = idx[7:0];
      chk_bus  = (t.op == OP_WR) || (t.op == OP_RD);
      chk_kind = t.chk;
      chk_exp  = t.exp;
      chk_stb  = 1'b1;
      @(negedge wb_clk);
      chk_stb  = 1'b0;
   endtask

   initial
   begin
      wb_clk   = 1'b0;
      wb_rst   = 1'b1;
      wb_adr   = '0;
      wb_wdat  = '0;
      wb_we    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      cgen_st  = 3'd0;
      pps      = 1'b0;
      chk_stb  = 1'b0;
      chk_bus  = 1'b0;
      chk_idx  = '0;
      chk_kind = CHK_NONE;
      chk_exp  = '0;
      lfsr_q   = 16'd69;
      build_table();
      repeat (RST_CYCLES) @(negedge wb_clk);
      wb_rst = 1'b0;
      @(negedge wb_clk);
      for (int i = 0; i < N_TESTS; i++)
         run_test(i);
      @(negedge wb_clk);
      $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
      if ((fail_cnt == 0) && (pass_cnt == N_TESTS))
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/u1_ctrl_pkg.sv
logic/wb_slave_decode.sv
logic/misc_regs.sv
logic/settings_bridge.sv
logic/reset_ctrl.sv
logic/time_keeper.sv
logic/status_readback.sv
logic/u1_ctrl_core.sv
bench/ctrl_checker.sv
bench/tb_u1_ctrl.sv

// ==== logic/misc_regs.sv ====
////////////////////////////////////////////////////////////
// misc control registers
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module misc_regs
   (input  wire                   wb_clk,
    input  wire                   rst_i,
    input  u1_ctrl_pkg::bus_req_t req_i,
    input  wire                   stb_i,
    input  wire [2:0]             cgen_st_i,   // status, lock detect, refmon
    output u1_ctrl_pkg::wb_data_t rd_dat_o,
    output logic [2:0]            debug_led_o,
    output logic                  cgen_sync_b_o,
    output logic                  cgen_ref_sel_o);

   u1_ctrl_pkg::wb_data_t reg_leds_q, reg_cgen_ctrl_q, reg_test_q;
   logic [6:0]            offs;

   assign offs = req_i.adr[6:0];

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         reg_leds_q      <= '0;
         reg_cgen_ctrl_q <= u1_ctrl_pkg::CGEN_CTRL_RESET;
         reg_test_q      <= '0;
      end
      else if (stb_i & req_i.we)
      begin
         case (offs)
            u1_ctrl_pkg::REG_LEDS      : reg_leds_q      <= req_i.dat;
            u1_ctrl_pkg::REG_CGEN_CTRL : reg_cgen_ctrl_q <= req_i.dat;
            u1_ctrl_pkg::REG_TEST      : reg_test_q      <= req_i.dat;
            default                    : ;   // read-only or unmapped
         endcase
      end
   end

   // board LEDs are wired out of order
   assign {debug_led_o[2], debug_led_o[0], debug_led_o[1]} = reg_leds_q[2:0];
   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl_q[1:0];

   always_comb
   begin
      case (offs)
         u1_ctrl_pkg::REG_LEDS      : rd_dat_o = reg_leds_q;
         u1_ctrl_pkg::REG_CGEN_CTRL : rd_dat_o = reg_cgen_ctrl_q;
         u1_ctrl_pkg::REG_CGEN_ST   : rd_dat_o = {13'd0, cgen_st_i};
         u1_ctrl_pkg::REG_TEST      : rd_dat_o = reg_test_q;
         u1_ctrl_pkg::REG_COMPAT    : rd_dat_o = {8'd0, u1_ctrl_pkg::COMPAT_NUM};
         default                    : rd_dat_o = u1_ctrl_pkg::UNMAPPED_DATA;
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/reset_ctrl.sv ====
////////////////////////////////////////////////////////////
// core reset control
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl
  #(parameter int RESET_HOLD = 4)
   (input  wire                   wb_clk,
    input  wire                   wb_rst,
    input  u1_ctrl_pkg::set_bus_t set_i,
    output logic                  core_rst_o);

   localparam int CW = $clog2(RESET_HOLD + 1);

   logic          global_req;
   logic [CW-1:0] hold_cnt_q;

   // any write to the register requests a reset
   assign global_req = set_i.stb & (set_i.addr == u1_ctrl_pkg::SR_GLOBAL_RESET);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         hold_cnt_q <= '0;
      else if (global_req)
         hold_cnt_q <= CW'(RESET_HOLD);
      else if (hold_cnt_q != '0)
         hold_cnt_q <= hold_cnt_q - 1'b1;
   end

   assign core_rst_o = wb_rst | (hold_cnt_q != '0);

endmodule

`default_nettype wire

// ==== logic/settings_bridge.sv ====
////////////////////////////////////////////////////////////
// 16 to 32 bit settings bridge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module settings_bridge
   (input  wire                   wb_clk,
    input  wire                   rst_i,
    input  u1_ctrl_pkg::bus_req_t req_i,
    input  wire                   stb_i,
    output u1_ctrl_pkg::set_bus_t set_o);

   u1_ctrl_pkg::wb_data_t  lo_half_q;   // waits for the high half
   u1_ctrl_pkg::set_addr_t addr_q;
   u1_ctrl_pkg::set_data_t data_q;
   logic                   set_stb_q;
   logic                   wr_lo, wr_hi;

   assign wr_lo = stb_i & req_i.we & ~req_i.adr[1];
   assign wr_hi = stb_i & req_i.we &  req_i.adr[1];

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         set_stb_q <= 1'b0;
      else
         set_stb_q <= wr_hi;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_lo)
         lo_half_q <= req_i.dat;
      if (wr_hi)
      begin
         addr_q <= req_i.adr[7:2];   // bit 7 picks slave 8 or 9
         data_q <= {req_i.dat, lo_half_q};
      end
   end

   assign set_o = '{stb: set_stb_q, addr: addr_q, data: data_q};

   // each bus write gives exactly one settings strobe
   set_stb_pulse : assert property (@(posedge wb_clk) disable iff (rst_i)
      set_o.stb |=> !set_o.stb);

endmodule

`default_nettype wire

// ==== logic/status_readback.sv ====
////////////////////////////////////////////////////////////
// 32 bit readback slave
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module status_readback
   (input  wire                     wb_clk,
    input  wire                     rst_i,
    input  u1_ctrl_pkg::bus_req_t   req_i,
    input  wire                     stb_i,
    input  u1_ctrl_pkg::set_bus_t   set_i,
    input  u1_ctrl_pkg::vita_time_t vita_time_i,
    input  u1_ctrl_pkg::vita_time_t vita_time_pps_i,
    output u1_ctrl_pkg::wb_data_t   rd_dat_o);

   u1_ctrl_pkg::set_data_t scratch_q;
   u1_ctrl_pkg::set_data_t word_sel;
   u1_ctrl_pkg::set_data_t word_latch_q;
   logic [4:0]             word_idx;

   assign word_idx = req_i.adr[6:2];

   // loopback scratch word
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         scratch_q <= '0;
      else if (set_i.stb & (set_i.addr == u1_ctrl_pkg::SR_REG_TEST32))
         scratch_q <= set_i.data;
   end

   always_comb
   begin
      case (word_idx)
         5'd0    : word_sel = vita_time_i[63:32];       // seconds
         5'd1    : word_sel = vita_time_i[31:0];        // ticks
         5'd2    : word_sel = vita_time_pps_i[63:32];
         5'd3    : word_sel = vita_time_pps_i[31:0];
         5'd4    : word_sel = scratch_q;
         default : word_sel = '0;
      endcase
   end

   // low half read freezes the word so both halves match
   always_ff @(posedge wb_clk)
   begin
      if (stb_i & ~req_i.we & ~req_i.adr[1])
         word_latch_q <= word_sel;
   end

   assign rd_dat_o = req_i.adr[1] ? word_latch_q[31:16] : word_sel[15:0];

endmodule

`default_nettype wire

// ==== logic/time_keeper.sv ====
////////////////////////////////////////////////////////////
// 64 bit time keeper with pps capture
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module time_keeper
  #(parameter logic [31:0] TICKS_PER_SEC = 32'd64000000)
   (input  wire                     wb_clk,
    input  wire                     rst_i,
    input  u1_ctrl_pkg::set_bus_t   set_i,
    input  wire                     pps_i,
    output u1_ctrl_pkg::vita_time_t vita_time_o,
    output u1_ctrl_pkg::vita_time_t vita_time_pps_o);

   u1_ctrl_pkg::vita_time_t time_q, pps_time_q;
   u1_ctrl_pkg::set_data_t  secs_load_q;
   u1_ctrl_pkg::vita_time_t load_val;
   logic                    pps_mode_q, armed_q;
   logic [2:0]              pps_sync_q;   // two sync flops and edge history
   logic                    pps_edge;
   logic                    wr_secs, wr_ticks, wr_mode;

   assign wr_secs  = set_i.stb & (set_i.addr == u1_ctrl_pkg::SR_TIME64);
   assign wr_ticks = set_i.stb & (set_i.addr == u1_ctrl_pkg::SR_TIME64 + 6'd1);
   assign wr_mode  = set_i.stb & (set_i.addr == u1_ctrl_pkg::SR_TIME64 + 6'd2);

   assign pps_edge = pps_sync_q[1] & ~pps_sync_q[2];

   ////////////////////////////////////////////////////////////
   // pending load value
   always_ff @(posedge wb_clk)
   begin
      if (wr_secs)
         secs_load_q <= set_i.data;
      if (wr_ticks)
         load_val <= {secs_load_q, set_i.data};
   end

   ////////////////////////////////////////////////////////////
   // counter, load and capture
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         time_q     <= '0;
         pps_time_q <= '0;
         pps_mode_q <= 1'b0;
         armed_q    <= 1'b0;
         pps_sync_q <= '0;
      end
      else
      begin
         pps_sync_q <= {pps_sync_q[1:0], pps_i};
         if (wr_mode)
            pps_mode_q <= set_i.data[0];

         if (wr_ticks & ~pps_mode_q)
            time_q <= {secs_load_q, set_i.data};   // immediate load
         else if (pps_edge & armed_q)
            time_q <= load_val;
         else if (time_q[31:0] == TICKS_PER_SEC - 1)
            time_q <= {time_q[63:32] + 1'b1, 32'd0};   // next second
         else
            time_q[31:0] <= time_q[31:0] + 1'b1;

         if (wr_ticks & pps_mode_q)
            armed_q <= 1'b1;
         else if (pps_edge)
            armed_q <= 1'b0;

         if (pps_edge)
            pps_time_q <= armed_q ? load_val : time_q;
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = pps_time_q;

endmodule

`default_nettype wire

// ==== logic/u1_ctrl_core.sv ====
////////////////////////////////////////////////////////////
// control plane top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module u1_ctrl_core
  #(parameter logic [31:0] TICKS_PER_SEC = 32'd64000000,
    parameter int          RESET_HOLD    = 4)
   (input  wire                   wb_clk,
    input  wire                   wb_rst,
    input  u1_ctrl_pkg::wb_addr_t wb_adr_i,
    input  u1_ctrl_pkg::wb_data_t wb_dat_i,
    input  wire                   wb_we_i,
    input  wire                   wb_cyc_i,
    input  wire                   wb_stb_i,
    output u1_ctrl_pkg::wb_data_t wb_dat_o,
    output logic                  wb_ack_o,
    input  wire [2:0]             cgen_st_i,
    input  wire                   pps_i,
    output logic [2:0]            debug_led_o,
    output logic                  cgen_sync_b_o,
    output logic                  cgen_ref_sel_o);

   u1_ctrl_pkg::bus_req_t   req;
   u1_ctrl_pkg::wb_data_t   misc_dat, rb_dat;
   u1_ctrl_pkg::set_bus_t   set_bus;
   u1_ctrl_pkg::vita_time_t vita_time, vita_time_pps;
   logic                    misc_stb, rb_stb, set_stb;
   logic                    core_rst;

   ////////////////////////////////////////////////////////////
   // bus decode and slaves
   wb_slave_decode u_decode
     (.wb_clk(wb_clk), .rst_i(core_rst),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .req_o(req), .misc_stb_o(misc_stb), .rb_stb_o(rb_stb), .set_stb_o(set_stb),
      .misc_dat_i(misc_dat), .rb_dat_i(rb_dat),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o));

   misc_regs u_misc
     (.wb_clk(wb_clk), .rst_i(core_rst), .req_i(req), .stb_i(misc_stb),
      .cgen_st_i(cgen_st_i), .rd_dat_o(misc_dat), .debug_led_o(debug_led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   settings_bridge u_bridge
     (.wb_clk(wb_clk), .rst_i(core_rst), .req_i(req), .stb_i(set_stb),
      .set_o(set_bus));

   // board reset plus the global reset setting
   reset_ctrl #(.RESET_HOLD(RESET_HOLD)) u_reset
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus), .core_rst_o(core_rst));

   ////////////////////////////////////////////////////////////
   // timing and readback
   time_keeper #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_time
     (.wb_clk(wb_clk), .rst_i(core_rst), .set_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   status_readback u_readback
     (.wb_clk(wb_clk), .rst_i(core_rst), .req_i(req), .stb_i(rb_stb),
      .set_i(set_bus), .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .rd_dat_o(rb_dat));

endmodule

`default_nettype wire

// ==== logic/u1_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// control plane shared definitions
////////////////////////////////////////////////////////////
`default_nettype none

package u1_ctrl_pkg;

   localparam int WB_DW  = 16;
   localparam int WB_AW  = 11;
   localparam int SET_AW = 6;     // 64 settings registers
   localparam int SET_DW = 32;
   localparam int TIME_W = 64;    // seconds in upper half, ticks in lower

   typedef logic [WB_DW-1:0]  wb_data_t;
   typedef logic [WB_AW-1:0]  wb_addr_t;
   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [SET_DW-1:0] set_data_t;
   typedef logic [TIME_W-1:0] vita_time_t;

   // request fields seen by every slave
   typedef struct packed {
      wb_addr_t adr;
      wb_data_t dat;
      logic     we;
   } bus_req_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // slave numbers from adr[10:7]
   localparam logic [3:0] SLV_MISC     = 4'd0;
   localparam logic [3:0] SLV_READBACK = 4'd7;
   localparam logic [3:0] SLV_SETTINGS = 4'd8;   // slaves 8 and 9

   localparam set_addr_t SR_TIME64       = 6'd42;   // +0 secs, +1 ticks, +2 pps mode
   localparam set_addr_t SR_REG_TEST32   = 6'd60;
   localparam set_addr_t SR_GLOBAL_RESET = 6'd63;

   // misc slave byte offsets
   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;
   localparam logic [6:0] REG_COMPAT    = 7'd16;

   localparam logic [7:0] COMPAT_NUM      = 8'd5;
   localparam wb_data_t   CGEN_CTRL_RESET = 16'd3;
   localparam wb_data_t   UNMAPPED_DATA   = 16'hBEEF;

endpackage

`default_nettype wire

// ==== logic/wb_slave_decode.sv ====
////////////////////////////////////////////////////////////
// single master slave decoder
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wb_slave_decode
   (input  wire                   wb_clk,
    input  wire                   rst_i,
    input  u1_ctrl_pkg::wb_addr_t wb_adr_i,
    input  u1_ctrl_pkg::wb_data_t wb_dat_i,
    input  wire                   wb_we_i,
    input  wire                   wb_cyc_i,
    input  wire                   wb_stb_i,
    output u1_ctrl_pkg::bus_req_t req_o,
    output logic                  misc_stb_o,
    output logic                  rb_stb_o,
    output logic                  set_stb_o,
    input  u1_ctrl_pkg::wb_data_t misc_dat_i,
    input  u1_ctrl_pkg::wb_data_t rb_dat_i,
    output u1_ctrl_pkg::wb_data_t wb_dat_o,
    output logic                  wb_ack_o);

   logic [3:0]            slv;
   logic                  req_seen_q;   // request already sampled once
   logic                  access;
   logic                  ack_q;
   u1_ctrl_pkg::wb_data_t rd_mux, dat_q;

   assign slv    = wb_adr_i[10:7];
   assign access = wb_cyc_i & wb_stb_i & ~req_seen_q;   // first cycle only

   assign req_o = '{adr: wb_adr_i, dat: wb_dat_i, we: wb_we_i};

   assign misc_stb_o = access & (slv == u1_ctrl_pkg::SLV_MISC);
   assign rb_stb_o   = access & (slv == u1_ctrl_pkg::SLV_READBACK);
   assign set_stb_o  = access & (slv[3:1] == u1_ctrl_pkg::SLV_SETTINGS[3:1]);

   // settings slave is write only
   always_comb
   begin
      if (slv == u1_ctrl_pkg::SLV_MISC)
         rd_mux = misc_dat_i;
      else if (slv == u1_ctrl_pkg::SLV_READBACK)
         rd_mux = rb_dat_i;
      else
         rd_mux = u1_ctrl_pkg::UNMAPPED_DATA;
   end

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         req_seen_q <= 1'b0;
         ack_q      <= 1'b0;
      end
      else
      begin
         req_seen_q <= wb_cyc_i & wb_stb_i;
         ack_q      <= access;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (access)
         dat_q <= rd_mux;   // held until the next request
   end

   assign wb_dat_o = dat_q;
   assign wb_ack_o = ack_q;

   // one-cycle acknowledge, master must drop stb after it
   ack_single_cycle : assert property (@(posedge wb_clk) disable iff (rst_i)
      wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire
